// ==== Makefile ====
TOP = spi_top_apb_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== rtl/apb_bus_pkg.sv ====
package apb_bus_pkg;

  // Byte address as seen on APB
  typedef logic [31:0] paddr_t;

  // Data word
  // Same width on APB and on the register port
  typedef logic [31:0] word_t;

  // One strobe per byte lane of a word
  typedef logic [3:0] strb_t;

  // Register offset inside the SPI window
  // Low five address bits only
  typedef logic [4:0] reg_addr_t;

endpackage

// ==== rtl/spi_core_pkg.sv ====
`include "spi_defines.svh"

package spi_core_pkg;

  // Bits per character, 0 stands for the maximum
  typedef logic [$clog2(`SPI_MAX_CHAR):0] char_len_t;

  // Half period of SCK minus one, in clocks
  typedef logic [15:0] divider_t;

  // One bit per slave select line
  typedef logic [`SPI_SS_NUM-1:0] ss_mask_t;

  // Shift register for TX and RX
  typedef logic [`SPI_MAX_CHAR-1:0] shift_t;

  // XIP sequencer steps
  typedef enum logic [2:0] {
    XIP_IDLE,
    XIP_SEND_CMD,
    XIP_SET_DIVIDER,
    XIP_SET_SS,
    XIP_GO_BUSY,
    XIP_WAIT_COMPLETE,
    XIP_READ_DATA,
    XIP_DONE
  } xip_state_t;

  // Shift engine phases
  // LEAD has SCK low, TRAIL has SCK high
  typedef enum logic [1:0] {
    SH_IDLE,
    SH_LEAD,
    SH_TRAIL,
    SH_FINISH
  } shift_state_t;

endpackage

// ==== rtl/spi_defines.svh ====
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// XIP window of the serial NOR flash
`define FLASH_ADDR_START 32'h3000_0000
`define FLASH_ADDR_END   32'h3FFF_FFFF

// SPI master register window
`define SPI_BASE 32'h1000_1000
`define SPI_END  32'h1000_1FFF

// Register offsets inside the SPI window
`define REG_RX      5'h00
`define REG_TX      5'h04
// Upper TX word, bits 63:32
`define REG_TX_HI   5'h08
`define REG_CTRL    5'h10
`define REG_DIVIDER 5'h14
`define REG_SS      5'h18

// CTRL bit positions
`define CTRL_GO_BIT 8
`define CTRL_IE_BIT 12

// Core dimensions
`define SPI_SS_NUM   8
`define SPI_MAX_CHAR 64

// XIP transfer setup
`define XIP_DIVIDER    1
`define FLASH_READ_CMD 8'h03

`endif

// ==== rtl/spi_master_regs.sv ====
`include "spi_defines.svh"

module spi_master_regs (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   reg_req_i,
  input  logic                   reg_we_i,
  input  apb_bus_pkg::reg_addr_t reg_addr_i,
  input  apb_bus_pkg::word_t     reg_wdata_i,
  input  apb_bus_pkg::strb_t     reg_be_i,
  output logic                   reg_ack_o,
  output apb_bus_pkg::word_t     reg_rdata_o,
  output logic                   spi_sck_o,
  output spi_core_pkg::ss_mask_t spi_ss_o,
  output logic                   spi_mosi_o,
  input  logic                   spi_miso_i,
  output logic                   irq_o
);
  import apb_bus_pkg::*;
  import spi_core_pkg::*;

  logic ack_q;
  logic access;
  logic wr_en;
  logic wr_ctrl;
  logic launch;
  word_t wr_mask;
  word_t ctrl_word;
  word_t ctrl_new;
  word_t div_new;
  word_t ss_new;
  word_t rd_word;
  shift_t tx_q;
  word_t rx_q;
  char_len_t len_q;
  logic go_q;
  logic ie_q;
  divider_t div_q;
  ss_mask_t ss_q;
  logic start_q;
  logic eng_busy;
  logic eng_done;
  word_t eng_rx;

  // Keep old bytes where the strobe is low
  function automatic word_t merge(word_t old_w, word_t new_w, word_t mask);
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  // One access per request until the ack
  assign access = reg_req_i & ~ack_q;
  assign wr_en = access & reg_we_i;
  assign wr_ctrl = wr_en & (reg_addr_i == `REG_CTRL);
  assign wr_mask = {{8{reg_be_i[3]}}, {8{reg_be_i[2]}}, {8{reg_be_i[1]}}, {8{reg_be_i[0]}}};

  always_comb begin
    ctrl_word = '0;
    ctrl_word[$bits(char_len_t)-1:0] = len_q;
    ctrl_word[`CTRL_GO_BIT] = go_q;
    ctrl_word[`CTRL_IE_BIT] = ie_q;
  end

  assign ctrl_new = merge(ctrl_word, reg_wdata_i, wr_mask);
  assign div_new = merge(word_t'(div_q), reg_wdata_i, wr_mask);
  assign ss_new = merge(word_t'(ss_q), reg_wdata_i, wr_mask);
  // Writes of GO while a character runs are dropped
  assign launch = wr_ctrl & ctrl_new[`CTRL_GO_BIT] & ~go_q;

  always_comb begin
    case (reg_addr_i)
      `REG_RX:      rd_word = rx_q;
      `REG_TX:      rd_word = tx_q[31:0];
      `REG_TX_HI:   rd_word = tx_q[63:32];
      `REG_CTRL:    rd_word = ctrl_word;
      `REG_DIVIDER: rd_word = word_t'(div_q);
      `REG_SS:      rd_word = word_t'(ss_q);
      default:      rd_word = '0;
    endcase
  end

  // Control registers
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ack_q <= 1'b0;
      len_q <= '0;
      go_q <= 1'b0;
      ie_q <= 1'b0;
      div_q <= '0;
      ss_q <= '0;
      start_q <= 1'b0;
      irq_o <= 1'b0;
    end else begin
      ack_q <= access;
      start_q <= launch;
      if (wr_ctrl) begin
        len_q <= ctrl_new[$bits(char_len_t)-1:0];
        ie_q <= ctrl_new[`CTRL_IE_BIT];
      end
      if (wr_en && reg_addr_i == `REG_DIVIDER) begin
        div_q <= div_new[15:0];
      end
      if (wr_en && reg_addr_i == `REG_SS) begin
        ss_q <= ss_new[`SPI_SS_NUM-1:0];
      end
      // GO_BSY stays set until the engine finishes
      if (eng_done) begin
        go_q <= 1'b0;
      end else if (launch) begin
        go_q <= 1'b1;
      end
      // Any CTRL write clears a pending interrupt
      if (eng_done && ie_q) begin
        irq_o <= 1'b1;
      end else if (wr_ctrl) begin
        irq_o <= 1'b0;
      end
    end
  end

  // TX, RX and read data
  always_ff @(posedge clock) begin
    if (wr_en && reg_addr_i == `REG_TX) begin
      tx_q[31:0] <= merge(tx_q[31:0], reg_wdata_i, wr_mask);
    end
    if (wr_en && reg_addr_i == `REG_TX_HI) begin
      tx_q[63:32] <= merge(tx_q[63:32], reg_wdata_i, wr_mask);
    end
    if (eng_done) begin
      rx_q <= eng_rx;
    end
    if (access && !reg_we_i) begin
      reg_rdata_o <= rd_word;
    end
  end

  assign reg_ack_o = ack_q;

  // Selected lines low only during a character
  assign spi_ss_o = eng_busy ? ~ss_q : '1;

  spi_shift_engine shift_engine_inst (
    .clock     (clock),
    .reset     (reset),
    .start_i   (start_q),
    .tx_data_i (tx_q),
    .char_len_i(len_q),
    .divider_i (div_q),
    .busy_o    (eng_busy),
    .done_o    (eng_done),
    .rx_data_o (eng_rx),
    .sck_o     (spi_sck_o),
    .mosi_o    (spi_mosi_o),
    .miso_i    (spi_miso_i)
  );

endmodule

// ==== rtl/spi_shift_engine.sv ====
`include "spi_defines.svh"

module spi_shift_engine (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   start_i,
  input  spi_core_pkg::shift_t    tx_data_i,
  input  spi_core_pkg::char_len_t char_len_i,
  input  spi_core_pkg::divider_t  divider_i,
  output logic                   busy_o,
  output logic                   done_o,
  output apb_bus_pkg::word_t     rx_data_o,
  output logic                   sck_o,
  output logic                   mosi_o,
  input  logic                   miso_i
);
  import spi_core_pkg::*;

  shift_state_t state_q;
  divider_t div_q;
  divider_t cnt_q;
  char_len_t bit_cnt_q;
  char_len_t bits;
  shift_t shift_q;
  logic sck_q;
  logic miso_q;
  logic half_end;
  logic load;

  // Zero or an oversize length means a full character
  assign bits = (char_len_i == '0 || char_len_i > char_len_t'(`SPI_MAX_CHAR)) ?
                char_len_t'(`SPI_MAX_CHAR) : char_len_i;
  assign half_end = (cnt_q == '0);
  assign load = (state_q == SH_IDLE) && start_i;

  // Phase and counter control
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q <= SH_IDLE;
      div_q <= '0;
      cnt_q <= '0;
      bit_cnt_q <= '0;
      sck_q <= 1'b0;
    end else begin
      case (state_q)
        SH_IDLE: begin
          if (start_i) begin
            div_q <= divider_i;
            cnt_q <= divider_i;
            bit_cnt_q <= bits;
            state_q <= SH_LEAD;
          end
        end
        SH_LEAD: begin
          if (half_end) begin
            // Rising edge
            sck_q <= 1'b1;
            cnt_q <= div_q;
            state_q <= SH_TRAIL;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        SH_TRAIL: begin
          if (half_end) begin
            // Falling edge ends one bit
            sck_q <= 1'b0;
            cnt_q <= div_q;
            bit_cnt_q <= bit_cnt_q - 1'b1;
            state_q <= (bit_cnt_q == char_len_t'(1)) ? SH_FINISH : SH_LEAD;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default: begin
          state_q <= SH_IDLE;
        end
      endcase
    end
  end

  // Shared TX and RX shift register
  always_ff @(posedge clock) begin
    if (load) begin
      // Align the top bit of the used length to the MSB
      shift_q <= tx_data_i << (char_len_t'(`SPI_MAX_CHAR) - bits);
    end else if (state_q == SH_LEAD && half_end) begin
      miso_q <= miso_i;
    end else if (state_q == SH_TRAIL && half_end) begin
      shift_q <= {shift_q[`SPI_MAX_CHAR-2:0], miso_q};
    end
  end

  assign busy_o = (state_q != SH_IDLE);
  assign done_o = (state_q == SH_FINISH);
  // Last 32 received bits sit at the bottom
  assign rx_data_o = shift_q[31:0];
  assign sck_o = sck_q;
  assign mosi_o = busy_o & shift_q[`SPI_MAX_CHAR-1];

endmodule

// ==== rtl/spi_top_apb.sv ====
`include "spi_defines.svh"

module spi_top_apb (
  input  logic                   clock,
  input  logic                   reset,
  input  apb_bus_pkg::paddr_t    paddr_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  apb_bus_pkg::word_t     pwdata_i,
  input  apb_bus_pkg::strb_t     pstrb_i,
  output logic                   pready_o,
  output apb_bus_pkg::word_t     prdata_o,
  output logic                   pslverr_o,
  output logic                   spi_sck_o,
  output spi_core_pkg::ss_mask_t spi_ss_o,
  output logic                   spi_mosi_o,
  input  logic                   spi_miso_i,
  output logic                   spi_irq_o
);
  import apb_bus_pkg::*;

  logic in_flash;
  logic in_spi;
  logic apb_access;
  logic xip_rd;
  logic bad_access;
  logic seq_req;
  logic seq_we;
  reg_addr_t seq_addr;
  word_t seq_wdata;
  strb_t seq_be;
  logic seq_done;
  word_t seq_data;
  logic reg_req;
  logic reg_we;
  reg_addr_t reg_addr;
  word_t reg_wdata;
  strb_t reg_be;
  logic reg_ack;
  word_t reg_rdata;

  // Address window decode
  assign in_flash = (paddr_i >= paddr_t'(`FLASH_ADDR_START)) &&
                    (paddr_i <= paddr_t'(`FLASH_ADDR_END));
  assign in_spi = (paddr_i >= paddr_t'(`SPI_BASE)) && (paddr_i <= paddr_t'(`SPI_END));
  assign apb_access = psel_i & penable_i;
  // Flash window is read only
  assign xip_rd = in_flash & ~pwrite_i;
  assign bad_access = apb_access & ~xip_rd & ~in_spi;

  // Register port owner
  // Sequencer inside the flash window, APB elsewhere
  assign reg_req = in_flash ? seq_req : (apb_access & in_spi);
  assign reg_we = in_flash ? seq_we : pwrite_i;
  assign reg_addr = in_flash ? seq_addr : paddr_i[4:0];
  assign reg_wdata = in_flash ? seq_wdata : pwdata_i;
  assign reg_be = in_flash ? seq_be : pstrb_i;

  // APB response
  assign pready_o = xip_rd ? seq_done : (in_spi ? reg_ack : bad_access);
  assign prdata_o = xip_rd ? seq_data : (in_spi ? reg_rdata : '0);
  assign pslverr_o = bad_access;

  spi_xip_sequencer xip_sequencer_inst (
    .clock       (clock),
    .reset       (reset),
    .start_i     (apb_access & xip_rd),
    .flash_addr_i(paddr_i[23:0]),
    .reg_req_o   (seq_req),
    .reg_we_o    (seq_we),
    .reg_addr_o  (seq_addr),
    .reg_wdata_o (seq_wdata),
    .reg_be_o    (seq_be),
    .reg_ack_i   (reg_ack),
    .reg_rdata_i (reg_rdata),
    .done_o      (seq_done),
    .data_o      (seq_data)
  );

  spi_master_regs master_regs_inst (
    .clock      (clock),
    .reset      (reset),
    .reg_req_i  (reg_req),
    .reg_we_i   (reg_we),
    .reg_addr_i (reg_addr),
    .reg_wdata_i(reg_wdata),
    .reg_be_i   (reg_be),
    .reg_ack_o  (reg_ack),
    .reg_rdata_o(reg_rdata),
    .spi_sck_o  (spi_sck_o),
    .spi_ss_o   (spi_ss_o),
    .spi_mosi_o (spi_mosi_o),
    .spi_miso_i (spi_miso_i),
    .irq_o      (spi_irq_o)
  );

endmodule

// ==== rtl/spi_xip_sequencer.sv ====
`include "spi_defines.svh"

module spi_xip_sequencer (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   start_i,
  input  logic [23:0]            flash_addr_i,
  output logic                   reg_req_o,
  output logic                   reg_we_o,
  output apb_bus_pkg::reg_addr_t reg_addr_o,
  output apb_bus_pkg::word_t     reg_wdata_o,
  output apb_bus_pkg::strb_t     reg_be_o,
  input  logic                   reg_ack_i,
  input  apb_bus_pkg::word_t     reg_rdata_i,
  output logic                   done_o,
  output apb_bus_pkg::word_t     data_o
);
  import apb_bus_pkg::*;
  import spi_core_pkg::*;

  xip_state_t state_q;
  logic [23:0] addr_q;
  word_t data_q;
  word_t ctrl_go;

  // CTRL value for a full 64-bit character with GO set
  always_comb begin
    ctrl_go = '0;
    ctrl_go[$bits(char_len_t)-1:0] = char_len_t'(`SPI_MAX_CHAR);
    ctrl_go[`CTRL_GO_BIT] = 1'b1;
  end

  // Step through the setup one acknowledge at a time
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q <= XIP_IDLE;
    end else begin
      case (state_q)
        XIP_IDLE: begin
          if (start_i) begin
            state_q <= XIP_SEND_CMD;
          end
        end
        XIP_SEND_CMD: begin
          if (reg_ack_i) begin
            state_q <= XIP_SET_DIVIDER;
          end
        end
        XIP_SET_DIVIDER: begin
          if (reg_ack_i) begin
            state_q <= XIP_SET_SS;
          end
        end
        XIP_SET_SS: begin
          if (reg_ack_i) begin
            state_q <= XIP_GO_BUSY;
          end
        end
        XIP_GO_BUSY: begin
          if (reg_ack_i) begin
            state_q <= XIP_WAIT_COMPLETE;
          end
        end
        XIP_WAIT_COMPLETE: begin
          // Poll again while GO_BSY still reads set
          if (reg_ack_i && !reg_rdata_i[`CTRL_GO_BIT]) begin
            state_q <= XIP_READ_DATA;
          end
        end
        XIP_READ_DATA: begin
          if (reg_ack_i) begin
            state_q <= XIP_DONE;
          end
        end
        default: begin
          state_q <= XIP_IDLE;
        end
      endcase
    end
  end

  // Flash address and returned word
  always_ff @(posedge clock) begin
    if (state_q == XIP_IDLE && start_i) begin
      addr_q <= flash_addr_i;
    end
    if (state_q == XIP_READ_DATA && reg_ack_i) begin
      data_q <= reg_rdata_i;
    end
  end

  // Register port request per step
  always_comb begin
    reg_req_o = 1'b1;
    reg_we_o = 1'b1;
    reg_be_o = 4'hF;
    reg_addr_o = `REG_CTRL;
    reg_wdata_o = '0;
    case (state_q)
      XIP_SEND_CMD: begin
        // Command byte then address in the top TX word
        reg_addr_o = `REG_TX_HI;
        reg_wdata_o = {`FLASH_READ_CMD, addr_q};
      end
      XIP_SET_DIVIDER: begin
        reg_addr_o = `REG_DIVIDER;
        reg_wdata_o = word_t'(`XIP_DIVIDER);
      end
      XIP_SET_SS: begin
        // Flash sits on select line 0
        reg_addr_o = `REG_SS;
        reg_wdata_o = word_t'(1);
      end
      XIP_GO_BUSY: begin
        reg_wdata_o = ctrl_go;
      end
      XIP_WAIT_COMPLETE: begin
        reg_we_o = 1'b0;
      end
      XIP_READ_DATA: begin
        reg_we_o = 1'b0;
        reg_addr_o = `REG_RX;
      end
      default: begin
        reg_req_o = 1'b0;
        reg_we_o = 1'b0;
      end
    endcase
  end

  assign done_o = (state_q == XIP_DONE);
  assign data_o = data_q;

endmodule

// ==== verification/spi_top_apb_chk.sv ====
module spi_top_apb_chk (
  input logic                   clock,
  input logic                   reset,
  input logic                   psel_i,
  input logic                   penable_i,
  input logic                   pready_o,
  input logic                   pslverr_o,
  input logic                   spi_sck_o,
  input spi_core_pkg::ss_mask_t spi_ss_o
);
  timeunit 1ns;
  timeprecision 1ns;

  // Error response completes the first access cycle
  err_with_ready: assert property (@(posedge clock) disable iff (reset)
    pslverr_o |-> (pready_o && psel_i && penable_i && !$past(penable_i)))
    else $error("pslverr outside the first access cycle or without pready");

  // Select lines frozen across every SCK edge
  ss_stable_on_sck: assert property (@(posedge clock) disable iff (reset)
    (spi_sck_o != $past(spi_sck_o)) |-> (spi_ss_o == $past(spi_ss_o)))
    else $error("SS changed together with an SCK edge");

  // Bus idle means a quiet clock line
  sck_quiet_idle: assert property (@(posedge clock) disable iff (reset)
    (&spi_ss_o) |-> (!spi_sck_o && $stable(spi_sck_o)))
    else $error("SCK active while no slave is selected");

endmodule

bind spi_top_apb spi_top_apb_chk spi_top_apb_chk_inst (
  .clock     (clock),
  .reset     (reset),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pready_o  (pready_o),
  .pslverr_o (pslverr_o),
  .spi_sck_o (spi_sck_o),
  .spi_ss_o  (spi_ss_o)
);

// ==== verification/spi_top_apb_tb.sv ====
`include "spi_defines.svh"

module spi_top_apb_tb;
  timeunit 1ns;
  timeprecision 1ns;
  import apb_bus_pkg::*;
  import spi_core_pkg::*;

  typedef enum logic [2:0] {
    OP_WR,
    OP_RD,
    OP_POLL,
    OP_IRQ,
    OP_SS
  } op_t;

  // One table row with a one-bit expected error
  typedef struct packed {
    op_t    op;
    paddr_t addr;
    word_t  data;
    strb_t  strb;
    word_t  exp;
    logic   err;
  } row_t;

  localparam paddr_t ADDR_RX = `SPI_BASE | 32'(`REG_RX);
  localparam paddr_t ADDR_TX = `SPI_BASE | 32'(`REG_TX);
  localparam paddr_t ADDR_TX_HI = `SPI_BASE | 32'(`REG_TX_HI);
  localparam paddr_t ADDR_CTRL = `SPI_BASE | 32'(`REG_CTRL);
  localparam paddr_t ADDR_DIV = `SPI_BASE | 32'(`REG_DIVIDER);
  localparam paddr_t ADDR_SS = `SPI_BASE | 32'(`REG_SS);

  logic clock;
  logic reset;
  paddr_t paddr;
  logic psel;
  logic penable;
  logic pwrite;
  word_t pwdata;
  strb_t pstrb;
  logic pready;
  word_t prdata;
  logic pslverr;
  logic spi_sck;
  ss_mask_t spi_ss;
  logic spi_mosi;
  logic spi_miso;
  logic spi_irq;

  row_t rows[$];
  logic [15:0] lfsr_q;
  int cycle_count;
  int cycle_limit;
  // Flash model state
  int flash_bits;
  logic [31:0] flash_cmd;
  word_t flash_resp;

  spi_top_apb spi_top_apb_inst (
    .clock     (clock),
    .reset     (reset),
    .paddr_i   (paddr),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .pwdata_i  (pwdata),
    .pstrb_i   (pstrb),
    .pready_o  (pready),
    .prdata_o  (prdata),
    .pslverr_o (pslverr),
    .spi_sck_o (spi_sck),
    .spi_ss_o  (spi_ss),
    .spi_mosi_o(spi_mosi),
    .spi_miso_i(spi_miso),
    .spi_irq_o (spi_irq)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  // Word a NOR flash returns for a byte address
  function automatic word_t flash_word(logic [23:0] a);
    return {8'h00, a} ^ 32'hA5C3_5A3C;
  endfunction

  // Old value with the strobed bytes replaced
  function automatic word_t byte_merge(word_t old_w, word_t new_w, strb_t strb);
    word_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output word_t v);
    v = '0;
    repeat (n) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Flash samples MOSI on the rising SCK edge
  always @(posedge spi_sck) begin
    if (!spi_ss[0]) begin
      if (flash_bits < 32) begin
        flash_cmd = {flash_cmd[30:0], spi_mosi};
      end
      flash_bits = flash_bits + 1;
      if (flash_bits == 32) begin
        flash_resp = (flash_cmd[31:24] == `FLASH_READ_CMD) ? flash_word(flash_cmd[23:0]) : '0;
      end
    end
  end

  // Data out MSB first on the falling edge
  always @(negedge spi_sck) begin
    if (!spi_ss[0] && flash_bits >= 32 && flash_bits < 64) begin
      spi_miso <= flash_resp[63 - flash_bits];
    end else begin
      spi_miso <= 1'b0;
    end
  end

  // Deselect ends the command
  always @(posedge spi_ss[0]) begin
    flash_bits = 0;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, the table did not finish", cycle_count);
      $display("Something failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      $display("Something failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // Setup, access, then wait for pready
  task automatic apb_transfer(input paddr_t addr, input logic write, input word_t data,
                              input strb_t strb, output word_t rdata, output logic err);
    @(negedge clock);
    paddr = addr;
    pwrite = write;
    pwdata = data;
    pstrb = write ? strb : 4'h0;
    psel = 1'b1;
    penable = 1'b0;
    @(negedge clock);
    penable = 1'b1;
    #10;
    while (!pready) begin
      @(negedge clock);
      #10;
    end
    rdata = prdata;
    err = pslverr;
    @(negedge clock);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pstrb = 4'h0;
  endtask

  task automatic apb_write(input paddr_t addr, input word_t data, input strb_t strb,
                           output logic err);
    word_t unused;
    apb_transfer(addr, 1'b1, data, strb, unused, err);
  endtask

  task automatic apb_read(input paddr_t addr, output word_t data, output logic err);
    apb_transfer(addr, 1'b0, '0, 4'h0, data, err);
  endtask

  task automatic add_row(input op_t op, input paddr_t addr, input word_t data,
                         input strb_t strb, input word_t exp, input logic err);
    row_t r;
    r.op = op;
    r.addr = addr;
    r.data = data;
    r.strb = strb;
    r.exp = exp;
    r.err = err;
    rows.push_back(r);
  endtask

  task automatic build_table();
    word_t d1;
    word_t d2;
    word_t a;
    word_t lo;
    word_t off;
    // Reset values
    add_row(OP_RD, ADDR_CTRL, '0, 4'h0, '0, 1'b0);
    add_row(OP_RD, ADDR_DIV, '0, 4'h0, '0, 1'b0);
    add_row(OP_RD, ADDR_SS, '0, 4'h0, '0, 1'b0);
    add_row(OP_IRQ, '0, '0, 4'h0, '0, 1'b0);
    add_row(OP_SS, '0, '0, 4'h0, 32'hFF, 1'b0);
    // Partial strobes on a 16-bit DIVIDER and an 8-bit SS
    draw_bits(32, d1);
    draw_bits(32, d2);
    add_row(OP_WR, ADDR_DIV, d1, 4'hF, '0, 1'b0);
    add_row(OP_WR, ADDR_DIV, d2, 4'h2, '0, 1'b0);
    add_row(OP_RD, ADDR_DIV, '0, 4'h0, byte_merge(d1, d2, 4'h2) & 32'hFFFF, 1'b0);
    add_row(OP_WR, ADDR_SS, d1, 4'hF, '0, 1'b0);
    add_row(OP_WR, ADDR_SS, d2, 4'h2, '0, 1'b0);
    add_row(OP_RD, ADDR_SS, '0, 4'h0, byte_merge(d1, d2, 4'h2) & 32'hFF, 1'b0);
    add_row(OP_WR, ADDR_SS, d2, 4'h1, '0, 1'b0);
    add_row(OP_RD, ADDR_SS, '0, 4'h0, d2 & 32'hFF, 1'b0);
    // Software read command as one 64-bit character
    draw_bits(24, a);
    draw_bits(32, lo);
    add_row(OP_WR, ADDR_TX_HI, {`FLASH_READ_CMD, a[23:0]}, 4'hF, '0, 1'b0);
    add_row(OP_WR, ADDR_TX, lo, 4'hF, '0, 1'b0);
    add_row(OP_RD, ADDR_TX_HI, '0, 4'h0, {`FLASH_READ_CMD, a[23:0]}, 1'b0);
    add_row(OP_WR, ADDR_DIV, 32'd2, 4'hF, '0, 1'b0);
    add_row(OP_WR, ADDR_SS, 32'd1, 4'hF, '0, 1'b0);
    add_row(OP_WR, ADDR_CTRL, 32'h0000_0140, 4'hF, '0, 1'b0);
    add_row(OP_POLL, ADDR_CTRL, '0, 4'h0, 32'h0000_0040, 1'b0);
    add_row(OP_RD, ADDR_RX, '0, 4'h0, flash_word(a[23:0]), 1'b0);
    add_row(OP_SS, '0, '0, 4'h0, 32'hFF, 1'b0);
    add_row(OP_IRQ, '0, '0, 4'h0, '0, 1'b0);
    // Same transfer with the interrupt enabled
    add_row(OP_WR, ADDR_CTRL, 32'h0000_1000, 4'hF, '0, 1'b0);
    add_row(OP_WR, ADDR_CTRL, 32'h0000_1140, 4'hF, '0, 1'b0);
    add_row(OP_POLL, ADDR_CTRL, '0, 4'h0, 32'h0000_1040, 1'b0);
    add_row(OP_IRQ, '0, '0, 4'h0, 32'h1, 1'b0);
    add_row(OP_RD, ADDR_RX, '0, 4'h0, flash_word(a[23:0]), 1'b0);
    add_row(OP_WR, ADDR_CTRL, 32'h0000_0040, 4'hF, '0, 1'b0);
    add_row(OP_IRQ, '0, '0, 4'h0, '0, 1'b0);
    // XIP reads at random window offsets
    repeat (5) begin
      draw_bits(28, off);
      add_row(OP_RD, `FLASH_ADDR_START | off, '0, 4'h0, flash_word(off[23:0]), 1'b0);
    end
    add_row(OP_RD, `FLASH_ADDR_END, '0, 4'h0, flash_word(24'hFF_FFFF), 1'b0);
    add_row(OP_SS, '0, '0, 4'h0, 32'hFF, 1'b0);
    // Sequencer leaves its setup behind
    add_row(OP_RD, ADDR_CTRL, '0, 4'h0, 32'h0000_0040, 1'b0);
    add_row(OP_RD, ADDR_DIV, '0, 4'h0, 32'(`XIP_DIVIDER), 1'b0);
    // Outside both windows and a flash write
    add_row(OP_RD, 32'h2000_0000, '0, 4'h0, '0, 1'b1);
    add_row(OP_WR, 32'h0000_0040, d1, 4'hF, '0, 1'b1);
    add_row(OP_WR, `FLASH_ADDR_START, d2, 4'hF, '0, 1'b1);
    add_row(OP_RD, 32'h1000_2000, '0, 4'h0, '0, 1'b1);
    add_row(OP_SS, '0, '0, 4'h0, 32'hFF, 1'b0);
  endtask

  initial begin
    word_t rd_data;
    logic err;
    string tag;
    reset = 1'b1;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    pstrb = 4'h0;
    spi_miso = 1'b0;
    flash_bits = 0;
    flash_cmd = '0;
    flash_resp = '0;
    cycle_count = 0;
    lfsr_q = 16'd13014;
    build_table();
    cycle_limit = rows.size() * 200;
    repeat (8) @(negedge clock);
    reset = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      tag = $sformatf("row %0d", i);
      case (rows[i].op)
        OP_WR: begin
          apb_write(rows[i].addr, rows[i].data, rows[i].strb, err);
          check_value({"pslverr ", tag}, 32'(err), 32'(rows[i].err));
        end
        OP_RD: begin
          apb_read(rows[i].addr, rd_data, err);
          check_value({"pslverr ", tag}, 32'(err), 32'(rows[i].err));
          check_value({"prdata ", tag}, rd_data, rows[i].exp);
        end
        OP_POLL: begin
          // Busy until GO_BSY reads clear
          rd_data = 32'h0000_0100;
          while (rd_data[`CTRL_GO_BIT] !== 1'b0) begin
            apb_read(rows[i].addr, rd_data, err);
            check_value({"pslverr ", tag}, 32'(err), 32'(rows[i].err));
          end
          check_value({"prdata ", tag}, rd_data, rows[i].exp);
        end
        OP_IRQ: begin
          @(negedge clock);
          check_value({"spi_irq ", tag}, 32'(spi_irq), rows[i].exp);
        end
        default: begin
          @(negedge clock);
          check_value({"spi_ss ", tag}, 32'(spi_ss), rows[i].exp);
        end
      endcase
    end
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/apb_bus_pkg.sv
rtl/spi_core_pkg.sv
rtl/spi_shift_engine.sv
rtl/spi_master_regs.sv
rtl/spi_xip_sequencer.sv
rtl/spi_top_apb.sv
verification/spi_top_apb_chk.sv
verification/spi_top_apb_tb.sv
